//--- source/pe_data_pkg.sv
`default_nettype none

package pe_data_pkg;

    localparam int PIXEL_W   = 8;
    localparam int WEIGHT_W  = 8;
    localparam int ACC_W     = 24;
    localparam int CHAN_W    = 4;
    localparam int ROW_LEN   = 8;
    localparam int BUF_DEPTH = 32;

    typedef logic [PIXEL_W-1:0]             pixel_t;
    typedef logic signed [WEIGHT_W-1:0]     weight_t;
    typedef logic signed [ACC_W-1:0]        acc_t;
    typedef logic [$clog2(BUF_DEPTH)-1:0]   addr_t;
    typedef logic [$clog2(ROW_LEN)-1:0]     col_t;
    typedef logic [CHAN_W-1:0]              chan_t;

    // Three horizontally adjacent pixels
    typedef struct packed {
        pixel_t p0;
        pixel_t p1;
        pixel_t p2;
    } window_t;

    typedef struct packed {
        weight_t w0;
        weight_t w1;
        weight_t w2;
        acc_t    bias;
    } kernel_t;

endpackage

`default_nettype wire

//--- source/pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

    typedef enum logic [3:0] {
        // Normal mode
        S_RESET,
        S_IDLE,
        S_LOAD_KERNEL,
        S_READY,
        S_WAIT_MID,
        S_WRITE_MID,
        S_WAIT_LAST,
        S_WRITE_LAST,
        S_ROW_RESET,
        // Last-channel mode
        S_IDLE_LC,
        S_READY_LC,
        S_WAIT_MID_LC,
        S_WRITE_MID_LC,
        S_WAIT_LAST_LC,
        S_WRITE_LAST_LC,
        S_FRAME_RESET
    } pe_state_t;

    // Strobes from decode to execute and result
    typedef struct packed {
        logic wr_kernel;
        logic buf_write;
        logic add_bias;
        logic emit;
        logic emit_last;
        logic addr_reset;
    } pe_ctrl_t;

endpackage

`default_nettype wire

//--- source/pe_control_unit.sv
`default_nettype none

module pe_control_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_kernel,
    input  logic                  stream_mid_row,
    input  logic                  stream_last_row,
    input  logic                  last_channel,
    input  logic                  mac_valid,
    input  logic                  row_end,
    output pe_ctrl_pkg::pe_ctrl_t ctrl,
    output logic                  pe_ready,
    output logic                  pe_idle
);

    pe_ctrl_pkg::pe_state_t state;
    pe_ctrl_pkg::pe_state_t next_state;
    pe_data_pkg::chan_t     chan_count;
    logic                   row_done;
    logic                   chan_done;

    // A write to the last column closes the row
    assign row_done = mac_valid & row_end;

    assign chan_done = row_done &&
                       (state == pe_ctrl_pkg::S_WAIT_LAST || state == pe_ctrl_pkg::S_WRITE_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pe_ctrl_pkg::S_RESET;
        end else begin
            state <= next_state;
        end
    end

    // Channels finished in normal mode
    // Zero selects bias seeding
    always_ff @(posedge clk) begin
        if (reset || state == pe_ctrl_pkg::S_FRAME_RESET) begin
            chan_count <= '0;
        end else if (chan_done) begin
            chan_count <= chan_count + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            pe_ctrl_pkg::S_RESET: next_state = pe_ctrl_pkg::S_IDLE;

            pe_ctrl_pkg::S_IDLE: begin
                if (load_kernel) begin
                    next_state = pe_ctrl_pkg::S_LOAD_KERNEL;
                end else if (stream_mid_row) begin
                    next_state = pe_ctrl_pkg::S_WAIT_MID;
                end else if (stream_last_row) begin
                    next_state = pe_ctrl_pkg::S_WAIT_LAST;
                end else if (last_channel) begin
                    next_state = pe_ctrl_pkg::S_IDLE_LC;
                end
            end

            pe_ctrl_pkg::S_LOAD_KERNEL: next_state = pe_ctrl_pkg::S_READY;
            pe_ctrl_pkg::S_READY:       next_state = pe_ctrl_pkg::S_IDLE;

            pe_ctrl_pkg::S_WAIT_MID, pe_ctrl_pkg::S_WRITE_MID: begin
                if (row_done) begin
                    next_state = pe_ctrl_pkg::S_IDLE;
                end else if (mac_valid) begin
                    next_state = pe_ctrl_pkg::S_WRITE_MID;
                end else begin
                    next_state = pe_ctrl_pkg::S_WAIT_MID;
                end
            end

            pe_ctrl_pkg::S_WAIT_LAST, pe_ctrl_pkg::S_WRITE_LAST: begin
                if (row_done) begin
                    next_state = pe_ctrl_pkg::S_ROW_RESET;
                end else if (mac_valid) begin
                    next_state = pe_ctrl_pkg::S_WRITE_LAST;
                end else begin
                    next_state = pe_ctrl_pkg::S_WAIT_LAST;
                end
            end

            pe_ctrl_pkg::S_ROW_RESET: next_state = pe_ctrl_pkg::S_IDLE;

            // Kernel loads straight from idle in this mode
            pe_ctrl_pkg::S_IDLE_LC: begin
                if (load_kernel) begin
                    next_state = pe_ctrl_pkg::S_READY_LC;
                end else if (stream_mid_row) begin
                    next_state = pe_ctrl_pkg::S_WAIT_MID_LC;
                end else if (stream_last_row) begin
                    next_state = pe_ctrl_pkg::S_WAIT_LAST_LC;
                end
            end

            pe_ctrl_pkg::S_READY_LC: next_state = pe_ctrl_pkg::S_IDLE_LC;

            pe_ctrl_pkg::S_WAIT_MID_LC, pe_ctrl_pkg::S_WRITE_MID_LC: begin
                if (row_done) begin
                    next_state = pe_ctrl_pkg::S_IDLE_LC;
                end else if (mac_valid) begin
                    next_state = pe_ctrl_pkg::S_WRITE_MID_LC;
                end else begin
                    next_state = pe_ctrl_pkg::S_WAIT_MID_LC;
                end
            end

            pe_ctrl_pkg::S_WAIT_LAST_LC, pe_ctrl_pkg::S_WRITE_LAST_LC: begin
                if (row_done) begin
                    next_state = pe_ctrl_pkg::S_FRAME_RESET;
                end else if (mac_valid) begin
                    next_state = pe_ctrl_pkg::S_WRITE_LAST_LC;
                end else begin
                    next_state = pe_ctrl_pkg::S_WAIT_LAST_LC;
                end
            end

            // Back to normal idle so the next frame can start
            pe_ctrl_pkg::S_FRAME_RESET: next_state = pe_ctrl_pkg::S_IDLE;

            default: next_state = pe_ctrl_pkg::S_IDLE;
        endcase
    end

    always_comb begin
        ctrl     = '0;
        pe_ready = 1'b0;
        pe_idle  = 1'b0;
        case (state)
            pe_ctrl_pkg::S_IDLE:        pe_idle = 1'b1;
            pe_ctrl_pkg::S_LOAD_KERNEL: ctrl.wr_kernel = 1'b1;

            pe_ctrl_pkg::S_READY, pe_ctrl_pkg::S_READY_LC: pe_ready = 1'b1;

            pe_ctrl_pkg::S_WAIT_MID, pe_ctrl_pkg::S_WRITE_MID,
            pe_ctrl_pkg::S_WAIT_LAST, pe_ctrl_pkg::S_WRITE_LAST: begin
                ctrl.buf_write = mac_valid;
                ctrl.add_bias  = (chan_count == '0);
            end

            pe_ctrl_pkg::S_ROW_RESET, pe_ctrl_pkg::S_FRAME_RESET: ctrl.addr_reset = 1'b1;

            pe_ctrl_pkg::S_IDLE_LC: begin
                pe_idle        = 1'b1;
                ctrl.wr_kernel = load_kernel;
            end

            pe_ctrl_pkg::S_WAIT_MID_LC, pe_ctrl_pkg::S_WRITE_MID_LC: begin
                ctrl.buf_write = mac_valid;
                ctrl.add_bias  = (chan_count == '0);
                ctrl.emit      = mac_valid;
            end

            pe_ctrl_pkg::S_WAIT_LAST_LC, pe_ctrl_pkg::S_WRITE_LAST_LC: begin
                ctrl.buf_write = mac_valid;
                ctrl.add_bias  = (chan_count == '0);
                ctrl.emit      = mac_valid;
                ctrl.emit_last = row_done;
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/pe_window_mac.sv
`default_nettype none

module pe_window_mac (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_kernel,
    input  pe_data_pkg::kernel_t  kernel,
    input  logic                  pixel_valid,
    input  pe_data_pkg::window_t  window,
    output logic                  mac_valid,
    output pe_data_pkg::acc_t     mac_sum,
    output pe_data_pkg::acc_t     bias
);

    pe_data_pkg::kernel_t kern_q;
    pe_data_pkg::acc_t    prod0;
    pe_data_pkg::acc_t    prod1;
    pe_data_pkg::acc_t    prod2;
    logic                 valid_s1;

    // Unsigned pixel times signed weight at full accumulator width
    function automatic pe_data_pkg::acc_t mul_px(
        input pe_data_pkg::pixel_t  px,
        input pe_data_pkg::weight_t w
    );
        pe_data_pkg::acc_t px_ext;
        pe_data_pkg::acc_t w_ext;
        px_ext = pe_data_pkg::acc_t'(px);
        w_ext  = pe_data_pkg::acc_t'(w);
        return px_ext * w_ext;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_kernel) begin
            kern_q <= kernel;
        end
    end

    assign bias = kern_q.bias;

    // Stage 1 products
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            prod0 <= mul_px(window.p0, kern_q.w0);
            prod1 <= mul_px(window.p1, kern_q.w1);
            prod2 <= mul_px(window.p2, kern_q.w2);
        end
    end

    // Stage 2 sum
    always_ff @(posedge clk) begin
        if (valid_s1) begin
            mac_sum <= prod0 + prod1 + prod2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1  <= 1'b0;
            mac_valid <= 1'b0;
        end else begin
            valid_s1  <= pixel_valid;
            mac_valid <= valid_s1;
        end
    end

endmodule

`default_nettype wire

//--- source/pe_accum_buffer.sv
`default_nettype none

module pe_accum_buffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              buf_write,
    input  logic              add_bias,
    input  logic              emit,
    input  logic              emit_last,
    input  logic              addr_reset,
    input  pe_data_pkg::acc_t mac_sum,
    input  pe_data_pkg::acc_t bias,
    output logic              row_end,
    output logic              out_valid,
    output logic              out_last,
    output pe_data_pkg::acc_t out_data
);

    pe_data_pkg::acc_t  mem [pe_data_pkg::BUF_DEPTH];
    pe_data_pkg::addr_t addr;
    pe_data_pkg::col_t  col;
    pe_data_pkg::acc_t  base;
    pe_data_pkg::acc_t  new_value;

    // Column is the low part of the address
    assign col     = addr[$bits(pe_data_pkg::col_t)-1:0];
    assign row_end = (col == pe_data_pkg::col_t'(pe_data_pkg::ROW_LEN - 1));

    // First channel starts from the bias, later ones from the stored partial sum
    assign base      = add_bias ? bias : mem[addr];
    assign new_value = base + mac_sum;

    always_ff @(posedge clk) begin
        if (reset || addr_reset) begin
            addr <= '0;
        end else if (buf_write) begin
            addr <= addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_write) begin
            mem[addr] <= new_value;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_write) begin
            out_data <= new_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= emit;
            out_last  <= emit_last;
        end
    end

endmodule

`default_nettype wire

//--- source/pe_with_buffers.sv
`default_nettype none

module pe_with_buffers (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_kernel,
    input  pe_data_pkg::kernel_t kernel,
    input  logic                 stream_mid_row,
    input  logic                 stream_last_row,
    input  logic                 last_channel,
    input  logic                 pixel_valid,
    input  pe_data_pkg::window_t window,
    output logic                 pe_ready,
    output logic                 pe_idle,
    output logic                 out_valid,
    output logic                 out_last,
    output pe_data_pkg::acc_t    out_data
);

    pe_ctrl_pkg::pe_ctrl_t ctrl;
    logic                  mac_valid;
    pe_data_pkg::acc_t     mac_sum;
    pe_data_pkg::acc_t     bias;
    logic                  row_end;

    // Decode
    pe_control_unit u_control (
        .clk             (clk),
        .reset           (reset),
        .load_kernel     (load_kernel),
        .stream_mid_row  (stream_mid_row),
        .stream_last_row (stream_last_row),
        .last_channel    (last_channel),
        .mac_valid       (mac_valid),
        .row_end         (row_end),
        .ctrl            (ctrl),
        .pe_ready        (pe_ready),
        .pe_idle         (pe_idle)
    );

    // Execute
    pe_window_mac u_mac (
        .clk         (clk),
        .reset       (reset),
        .wr_kernel   (ctrl.wr_kernel),
        .kernel      (kernel),
        .pixel_valid (pixel_valid),
        .window      (window),
        .mac_valid   (mac_valid),
        .mac_sum     (mac_sum),
        .bias        (bias)
    );

    // Result
    pe_accum_buffer u_buffer (
        .clk        (clk),
        .reset      (reset),
        .buf_write  (ctrl.buf_write),
        .add_bias   (ctrl.add_bias),
        .emit       (ctrl.emit),
        .emit_last  (ctrl.emit_last),
        .addr_reset (ctrl.addr_reset),
        .mac_sum    (mac_sum),
        .bias       (bias),
        .row_end    (row_end),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_data   (out_data)
    );

endmodule

`default_nettype wire

//--- dv/pe_tb_model.svh
`ifndef PE_TB_MODEL_SVH
`define PE_TB_MODEL_SVH

// Galois LFSR for polynomial x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state = 32'hf1d7;

// Kernel as currently loaded
int                model_w [3];
pe_data_pkg::acc_t model_bias;

pe_data_pkg::acc_t model_mem [pe_data_pkg::BUF_DEPTH];
pe_data_pkg::acc_t exp_data_q [$];
logic              exp_last_q [$];

// One LFSR step per bit with the first bit as the MSB of the result
function automatic logic [31:0] draw_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value      = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return value;
endfunction

task automatic model_load_kernel(input pe_data_pkg::kernel_t k);
    model_w[0] = int'($signed(k.w0));
    model_w[1] = int'($signed(k.w1));
    model_w[2] = int'($signed(k.w2));
    model_bias = k.bias;
endtask

// Unsigned pixels against signed weights
function automatic int window_dot(input pe_data_pkg::window_t win);
    return int'(win.p0) * model_w[0] + int'(win.p1) * model_w[1] + int'(win.p2) * model_w[2];
endfunction

// First channel seeds with the bias, later channels add to the stored sum
task automatic model_write(input pe_data_pkg::addr_t addr, input pe_data_pkg::window_t win,
                           input logic first_chan, input logic last_chan,
                           input logic frame_last);
    pe_data_pkg::acc_t base;
    pe_data_pkg::acc_t value;
    base            = first_chan ? model_bias : model_mem[addr];
    value           = pe_data_pkg::acc_t'(int'(base) + window_dot(win));
    model_mem[addr] = value;
    if (last_chan) begin
        exp_data_q.push_back(value);
        exp_last_q.push_back(frame_last);
    end
endtask

`endif

//--- dv/pe_with_buffers_tb.sv
`default_nettype none

module pe_with_buffers_tb;

    localparam int N_FRAMES       = 6;
    localparam int MAX_CHANNELS   = 4;
    localparam int MAX_ROWS       = 4;
    localparam int PIXEL_CYCLES   = 4;
    localparam int ROW_OVERHEAD   = 4;
    localparam int TIMEOUT_CYCLES = N_FRAMES * MAX_CHANNELS *
        (MAX_ROWS * pe_data_pkg::ROW_LEN * PIXEL_CYCLES + ROW_OVERHEAD) + 200;

    logic                 clk;
    logic                 reset;
    logic                 load_kernel;
    pe_data_pkg::kernel_t kernel;
    logic                 stream_mid_row;
    logic                 stream_last_row;
    logic                 last_channel;
    logic                 pixel_valid;
    pe_data_pkg::window_t window;
    logic                 pe_ready;
    logic                 pe_idle;
    logic                 out_valid;
    logic                 out_last;
    pe_data_pkg::acc_t    out_data;
    int                   cycle_count;

    `include "pe_tb_model.svh"

    pe_with_buffers dut0 (
        .clk             (clk),
        .reset           (reset),
        .load_kernel     (load_kernel),
        .kernel          (kernel),
        .stream_mid_row  (stream_mid_row),
        .stream_last_row (stream_last_row),
        .last_channel    (last_channel),
        .pixel_valid     (pixel_valid),
        .window          (window),
        .pe_ready        (pe_ready),
        .pe_idle         (pe_idle),
        .out_valid       (out_valid),
        .out_last        (out_last),
        .out_data        (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        assert (actual === expected) else begin
            $display("Mismatch at time %0t: %s is %0b, expected %0b", $time, name, actual,
                     expected);
            fail_run();
        end
    endtask

    task automatic check_value(input string name, input pe_data_pkg::acc_t actual,
                               input pe_data_pkg::acc_t expected);
        assert (actual === expected) else begin
            $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, actual,
                     expected);
            fail_run();
        end
    endtask

    task automatic wait_idle();
        while (!pe_idle) begin
            @(negedge clk);
        end
    endtask

    // Idle with the level high moves the unit into last-channel mode
    task automatic enter_last_channel();
        last_channel = 1'b1;
        @(negedge clk);
        last_channel = 1'b0;
        check_bit("pe_idle", pe_idle, 1'b1);
    endtask

    // pe_ready two cycles after the strobe in normal mode, one in last-channel mode
    task automatic load_and_check_kernel(input pe_data_pkg::kernel_t k, input logic lc_mode);
        int ready_at;
        ready_at    = lc_mode ? 1 : 2;
        kernel      = k;
        load_kernel = 1'b1;
        model_load_kernel(k);
        for (int n = 1; n <= 3; n++) begin
            @(negedge clk);
            load_kernel = 1'b0;
            check_bit("pe_ready", pe_ready, n == ready_at);
        end
        wait_idle();
    endtask

    task automatic stream_row(input int row, input logic last_row, input logic first_chan,
                              input logic last_chan);
        int                   gap;
        logic [31:0]          raw;
        pe_data_pkg::window_t win;
        pe_data_pkg::addr_t   addr;
        if (last_row) begin
            stream_last_row = 1'b1;
        end else begin
            stream_mid_row = 1'b1;
        end
        @(negedge clk);
        stream_mid_row  = 1'b0;
        stream_last_row = 1'b0;
        check_bit("pe_idle", pe_idle, 1'b0);
        for (int col = 0; col < pe_data_pkg::ROW_LEN; col++) begin
            gap = int'(draw_bits(2));
            repeat (gap) @(negedge clk);
            raw         = draw_bits(24);
            win         = raw[23:0];
            addr        = pe_data_pkg::addr_t'(row * pe_data_pkg::ROW_LEN + col);
            window      = win;
            pixel_valid = 1'b1;
            model_write(addr, win, first_chan, last_chan,
                        last_row && col == pe_data_pkg::ROW_LEN - 1);
            @(negedge clk);
            pixel_valid = 1'b0;
        end
        wait_idle();
    endtask

    // Every beat must match the head of the expected queue
    task automatic check_outputs();
        pe_data_pkg::acc_t exp_data;
        logic              exp_last;
        if (out_valid) begin
            assert (exp_data_q.size() > 0) else begin
                $display("Output beat at time %0t while no beat was expected", $time);
                fail_run();
            end
            exp_data = exp_data_q.pop_front();
            exp_last = exp_last_q.pop_front();
            check_value("out_data", out_data, exp_data);
            check_bit("out_last", out_last, exp_last);
        end else begin
            check_bit("out_last", out_last, 1'b0);
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                check_outputs();
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
        fail_run();
    end

    initial begin
        int                   n_chan;
        int                   n_rows;
        logic [31:0]          raw;
        pe_data_pkg::kernel_t k;

        reset           = 1'b1;
        load_kernel     = 1'b0;
        kernel          = '0;
        stream_mid_row  = 1'b0;
        stream_last_row = 1'b0;
        last_channel    = 1'b0;
        pixel_valid     = 1'b0;
        window          = '0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("out_last", out_last, 1'b0);
        check_bit("pe_ready", pe_ready, 1'b0);
        check_bit("pe_idle", pe_idle, 1'b0);
        reset = 1'b0;
        // One cycle in the reset state, then idle
        @(negedge clk);
        check_bit("pe_idle", pe_idle, 1'b1);
        check_bit("pe_ready", pe_ready, 1'b0);

        for (int frame = 0; frame < N_FRAMES; frame++) begin
            n_chan = 1 + int'(draw_bits(2));
            n_rows = 1 + int'(draw_bits(2));
            for (int chan = 0; chan < n_chan; chan++) begin
                if (chan == n_chan - 1) begin
                    enter_last_channel();
                end
                raw    = draw_bits(24);
                k.w0   = raw[7:0];
                k.w1   = raw[15:8];
                k.w2   = raw[23:16];
                raw    = draw_bits(24);
                k.bias = raw[23:0];
                load_and_check_kernel(k, chan == n_chan - 1);
                for (int row = 0; row < n_rows; row++) begin
                    stream_row(row, row == n_rows - 1, chan == 0, chan == n_chan - 1);
                end
            end
        end

        // Back in normal mode after the final frame
        load_and_check_kernel(k, 1'b0);
        repeat (4) @(negedge clk);

        if (exp_data_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d expected output beats never appeared", exp_data_q.size());
            fail_run();
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+dv
source/pe_data_pkg.sv
source/pe_ctrl_pkg.sv
source/pe_control_unit.sv
source/pe_window_mac.sv
source/pe_accum_buffer.sv
source/pe_with_buffers.sv
dv/pe_with_buffers_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := pe_with_buffers_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard dv/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Simulator output goes to the terminal, the pass line decides the status
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
